// File: hdl/dino_pkg.sv
// Dino runner shared definitions
`default_nettype none

package dino_pkg;

    typedef logic [10:0] coord_t;
    typedef logic [23:0] rgb_t;
    // Ten-thousands digit in the top nibble
    typedef logic [19:0] bcd_score_t;

    typedef enum logic {
        running = 1'b0,
        over    = 1'b1
    } game_mode_e;

    // 1280x480 raster, 1600x525 total frame
    localparam coord_t h_active = 11'd1280;
    localparam coord_t h_front  = 11'd32;
    localparam coord_t h_sync   = 11'd192;
    localparam coord_t h_back   = 11'd96;
    localparam coord_t h_total  = 11'd1600;

    localparam coord_t v_active = 11'd480;
    localparam coord_t v_front  = 11'd10;
    localparam coord_t v_sync   = 11'd2;
    localparam coord_t v_back   = 11'd33;
    localparam coord_t v_total  = 11'd525;

    // Dino stays put on the ground row
    localparam coord_t dino_x = 11'd100;
    localparam coord_t dino_y = 11'd348;
    localparam coord_t dino_w = 11'd32;
    localparam coord_t dino_h = 11'd32;

    localparam coord_t ground_y     = 11'd348;
    localparam coord_t cactus_start = 11'd1200;
    localparam coord_t group_start  = 11'd1600;
    localparam coord_t lava_start   = 11'd1800;
    localparam coord_t cactus_w     = 11'd32;
    localparam coord_t group_w      = 11'd150;
    localparam coord_t group_h      = 11'd40;
    localparam coord_t lava_w       = 11'd32;
    localparam coord_t obstacle_h   = 11'd32;

    // Score digits sit 16 pixels apart
    localparam coord_t score_x  = 11'd120;
    localparam coord_t score_y  = 11'd10;

    localparam coord_t banner_x = 11'd560;
    localparam coord_t banner_y = 11'd200;
    localparam coord_t banner_w = 11'd160;
    localparam coord_t banner_h = 11'd40;

    localparam logic [3:0] wraps_per_step = 4'd12;

    localparam rgb_t sky_rgb    = 24'h87_ce_eb;
    localparam rgb_t ink_rgb    = 24'h00_00_00;
    localparam rgb_t dino_rgb   = 24'h53_53_53;
    localparam rgb_t cactus_rgb = 24'h2e_8b_2e;
    localparam rgb_t lava_rgb   = 24'hff_45_00;
    localparam rgb_t banner_rgb = 24'hff_ff_ff;

endpackage

`default_nettype wire

// File: hdl/digit_font.sv
// 8x8 digit glyph ROM
`default_nettype none

module digit_font (
    input  logic [3:0] digit,
    input  logic [2:0] row,
    output logic [7:0] bits
);

    logic [63:0] glyph;

    // Top row in the high byte, leftmost pixel in bit 7
    always_comb begin
        case (digit)
            4'd0:    glyph = 64'h3c66_6e7e_7666_3c00;
            4'd1:    glyph = 64'h1838_1818_1818_7e00;
            4'd2:    glyph = 64'h3c66_061c_3066_7e00;
            4'd3:    glyph = 64'h3c66_061c_0666_3c00;
            4'd4:    glyph = 64'h0c1c_2c4c_7e0c_0c00;
            4'd5:    glyph = 64'h7e60_7c06_0666_3c00;
            4'd6:    glyph = 64'h3c66_607c_6666_3c00;
            4'd7:    glyph = 64'h7e06_0c18_3030_3000;
            4'd8:    glyph = 64'h3c66_663c_6666_3c00;
            4'd9:    glyph = 64'h3c66_663e_0666_3c00;
            default: glyph = 64'h0;
        endcase
    end

    assign bits = glyph[63 - 8*row -: 8];

endmodule

`default_nettype wire

// File: hdl/raster_timing.sv
// VGA raster counters and sync decode
`default_nettype none

module raster_timing
    import dino_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    output coord_t hcount,
    output coord_t vcount,
    output logic   hsync_raw,
    output logic   vsync_raw,
    output logic   blank_raw_n,
    output logic   vga_clk
);

    logic end_of_line;
    logic end_of_frame;

    assign end_of_line  = (hcount == h_total - 11'd1);
    assign end_of_frame = (vcount == v_total - 11'd1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
        end else if (end_of_line) begin
            hcount <= '0;
        end else begin
            hcount <= hcount + 11'd1;
        end
    end

    // Lines advance only when the pixel counter wraps
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vcount <= '0;
        end else if (end_of_line) begin
            if (end_of_frame) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 11'd1;
            end
        end
    end

    // Sync pulses are active low, after the front porch
    assign hsync_raw = !((hcount >= h_active + h_front) &&
                         (hcount < h_active + h_front + h_sync));
    assign vsync_raw = !((vcount >= v_active + v_front) &&
                         (vcount < v_active + v_front + v_sync));

    assign blank_raw_n = (hcount < h_active) && (vcount < v_active);

    // Pixel clock at half the system clock
    assign vga_clk = hcount[0];

endmodule

`default_nettype wire

// File: hdl/game_state.sv
// Obstacle motion, score and collision
`default_nettype none

module game_state
    import dino_pkg::*;
#(
    parameter int tick_cycles = 2_000_000
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       replay,
    output coord_t     cactus_x,
    output coord_t     group_x,
    output coord_t     lava_x,
    output bcd_score_t score,
    output game_mode_e mode
);

    localparam int cnt_w = $clog2(tick_cycles + 1);

    logic [cnt_w-1:0] tick_cnt;
    logic             tick;
    logic [5:0]       lfsr;
    coord_t           speed;
    logic [3:0]       wrap_count;
    logic             cactus_wrap;
    logic             group_wrap;
    logic             lava_wrap;
    logic             hit;

    function automatic logic boxes_overlap(input coord_t ax, ay, aw, ah,
                                           input coord_t bx, by, bw, bh);
        logic [11:0] ax_e;
        logic [11:0] ay_e;
        logic [11:0] bx_e;
        logic [11:0] by_e;
        ax_e = {1'b0, ax};
        ay_e = {1'b0, ay};
        bx_e = {1'b0, bx};
        by_e = {1'b0, by};
        return (ax_e < bx_e + bw) && (ax_e + aw > bx_e) &&
               (ay_e < by_e + bh) && (ay_e + ah > by_e);
    endfunction

    // Decimal increment with carry, 99999 rolls to 0
    function automatic bcd_score_t bcd_inc(input bcd_score_t value);
        bcd_score_t result;
        logic       carry;
        result = value;
        carry  = 1'b1;
        for (int i = 0; i < 5; i++) begin
            if (carry) begin
                if (result[4*i +: 4] == 4'd9) begin
                    result[4*i +: 4] = 4'd0;
                end else begin
                    result[4*i +: 4] = result[4*i +: 4] + 4'd1;
                    carry = 1'b0;
                end
            end
        end
        return result;
    endfunction

    assign tick = (mode == running) && (tick_cnt == cnt_w'(tick_cycles - 1));

    assign cactus_wrap = (cactus_x <= speed);
    assign group_wrap  = (group_x <= speed);
    assign lava_wrap   = (lava_x <= speed);

    assign hit = boxes_overlap(dino_x, dino_y, dino_w, dino_h,
                               cactus_x, ground_y, cactus_w, obstacle_h) ||
                 boxes_overlap(dino_x, dino_y, dino_w, dino_h,
                               group_x, ground_y, group_w, group_h) ||
                 boxes_overlap(dino_x, dino_y, dino_w, dino_h,
                               lava_x, ground_y, lava_w, obstacle_h);

    // Frozen while the game is over
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tick_cnt <= '0;
        end else if (mode == running) begin
            if (tick) begin
                tick_cnt <= '0;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cactus_x   <= cactus_start;
            group_x    <= group_start;
            lava_x     <= lava_start;
            speed      <= 11'd1;
            wrap_count <= '0;
            lfsr       <= 6'b101011;
            score      <= '0;
        end else if (mode == over) begin
            // Score carries on across a replay
            if (replay) begin
                cactus_x   <= cactus_start;
                group_x    <= group_start;
                lava_x     <= lava_start;
                speed      <= 11'd1;
                wrap_count <= '0;
            end
        end else if (tick) begin
            cactus_x <= cactus_wrap ? h_active + coord_t'({lfsr, 4'd0})
                                    : cactus_x - speed;
            group_x  <= group_wrap ? h_active + coord_t'({~lfsr, 4'd0})
                                   : group_x - speed;
            lava_x   <= lava_wrap ? h_active + coord_t'({lfsr[3:0], 6'd0})
                                  : lava_x - speed;
            score    <= bcd_inc(score);
            // x^6 + x^5 + 1
            lfsr     <= {lfsr[4:0], lfsr[5] ^ lfsr[4]};
            if (wrap_count >= wraps_per_step) begin
                speed      <= speed + 11'd1;
                wrap_count <= '0;
            end else if (cactus_wrap || group_wrap || lava_wrap) begin
                wrap_count <= wrap_count + 4'd1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mode <= running;
        end else if (mode == over) begin
            if (replay) begin
                mode <= running;
            end
        end else if (hit) begin
            mode <= over;
        end
    end

endmodule

`default_nettype wire

// File: hdl/pixel_compositor.sv
// Pixel layering and VGA output registers
`default_nettype none

module pixel_compositor
    import dino_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  coord_t     hcount,
    input  coord_t     vcount,
    input  logic       hsync_raw,
    input  logic       vsync_raw,
    input  logic       blank_raw_n,
    input  coord_t     cactus_x,
    input  coord_t     group_x,
    input  coord_t     lava_x,
    input  bcd_score_t score,
    input  game_mode_e mode,
    output rgb_t       rgb,
    output logic       hsync,
    output logic       vsync,
    output logic       blank_n
);

    coord_t     score_dx;
    coord_t     score_dy;
    logic [1:0] slot;
    logic [3:0] digit;
    logic [7:0] glyph_row;
    logic       digit_ink;
    rgb_t       pixel;

    function automatic logic in_box(input coord_t px, py, bx, by, bw, bh);
        logic [11:0] px_e;
        logic [11:0] py_e;
        logic [11:0] bx_e;
        logic [11:0] by_e;
        px_e = {1'b0, px};
        py_e = {1'b0, py};
        bx_e = {1'b0, bx};
        by_e = {1'b0, by};
        return (px_e >= bx_e) && (px_e < bx_e + bw) &&
               (py_e >= by_e) && (py_e < by_e + bh);
    endfunction

    // Offsets wrap high when left of or above the score origin
    assign score_dx = hcount - score_x;
    assign score_dy = vcount - score_y;
    assign slot     = score_dx[5:4];

    // Units digit is not shown
    always_comb begin
        case (slot)
            2'd0:    digit = score[19:16];
            2'd1:    digit = score[15:12];
            2'd2:    digit = score[11:8];
            default: digit = score[7:4];
        endcase
    end

    digit_font u_digit_font (
        .digit (digit),
        .row   (score_dy[2:0]),
        .bits  (glyph_row)
    );

    // Glyph covers the first 8 pixels of each 16-pixel slot
    assign digit_ink = (score_dx < 11'd64) && !score_dx[3] && (score_dy < 11'd8) &&
                       glyph_row[3'd7 - score_dx[2:0]];

    always_comb begin
        pixel = sky_rgb;
        if (mode == running) begin
            if (digit_ink) begin
                pixel = ink_rgb;
            end
            if (in_box(hcount, vcount, dino_x, dino_y, dino_w, dino_h)) begin
                pixel = dino_rgb;
            end
            if (in_box(hcount, vcount, cactus_x, ground_y, cactus_w, obstacle_h)) begin
                pixel = cactus_rgb;
            end
            if (in_box(hcount, vcount, group_x, ground_y, group_w, group_h)) begin
                pixel = cactus_rgb;
            end
            if (in_box(hcount, vcount, lava_x, ground_y, lava_w, obstacle_h)) begin
                pixel = lava_rgb;
            end
        end else if (in_box(hcount, vcount, banner_x, banner_y, banner_w, banner_h)) begin
            pixel = banner_rgb;
        end
    end

    // Syncs delayed one clock to line up with the colour register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hsync   <= 1'b1;
            vsync   <= 1'b1;
            blank_n <= 1'b0;
        end else begin
            hsync   <= hsync_raw;
            vsync   <= vsync_raw;
            blank_n <= blank_raw_n;
        end
    end

    always_ff @(posedge clk) begin
        rgb <= pixel;
    end

endmodule

`default_nettype wire

// File: hdl/dino_top.sv
// Dino runner top level
`default_nettype none

module dino_top
    import dino_pkg::*;
#(
    parameter int tick_cycles = 2_000_000
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       replay,
    output logic [7:0] vga_r,
    output logic [7:0] vga_g,
    output logic [7:0] vga_b,
    output logic       vga_hs,
    output logic       vga_vs,
    output logic       vga_blank_n,
    output logic       vga_clk,
    output bcd_score_t score,
    output logic       game_over
);

    coord_t     hcount;
    coord_t     vcount;
    logic       hsync_raw;
    logic       vsync_raw;
    logic       blank_raw_n;
    coord_t     cactus_x;
    coord_t     group_x;
    coord_t     lava_x;
    game_mode_e mode;
    rgb_t       rgb;

    game_state #(
        .tick_cycles (tick_cycles)
    ) u_game_state (
        .clk      (clk),
        .reset    (reset),
        .replay   (replay),
        .cactus_x (cactus_x),
        .group_x  (group_x),
        .lava_x   (lava_x),
        .score    (score),
        .mode     (mode)
    );

    raster_timing u_raster_timing (
        .clk         (clk),
        .reset       (reset),
        .hcount      (hcount),
        .vcount      (vcount),
        .hsync_raw   (hsync_raw),
        .vsync_raw   (vsync_raw),
        .blank_raw_n (blank_raw_n),
        .vga_clk     (vga_clk)
    );

    pixel_compositor u_pixel_compositor (
        .clk         (clk),
        .reset       (reset),
        .hcount      (hcount),
        .vcount      (vcount),
        .hsync_raw   (hsync_raw),
        .vsync_raw   (vsync_raw),
        .blank_raw_n (blank_raw_n),
        .cactus_x    (cactus_x),
        .group_x     (group_x),
        .lava_x      (lava_x),
        .score       (score),
        .mode        (mode),
        .rgb         (rgb),
        .hsync       (vga_hs),
        .vsync       (vga_vs),
        .blank_n     (vga_blank_n)
    );

    assign {vga_r, vga_g, vga_b} = rgb;
    assign game_over = (mode == over);

endmodule

`default_nettype wire

// File: verification/game_state_asserts.sv
// Game state rule checks
`default_nettype none

module game_state_asserts
    import dino_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       replay,
    input game_mode_e mode,
    input coord_t     speed,
    input logic [5:0] lfsr
);

    timeunit 1ns;
    timeprecision 1ps;

    // Leaving game over needs the replay strobe
    property over_holds_without_replay;
        @(posedge clk) disable iff (reset)
            (mode == over && !replay) |=> (mode == over);
    endproperty

    property speed_never_drops;
        @(posedge clk) disable iff (reset)
            !replay |=> (speed >= $past(speed));
    endproperty

    // All-zero state would lock the LFSR
    property lfsr_nonzero;
        @(posedge clk) disable iff (reset)
            lfsr != 6'd0;
    endproperty

    a_over_holds: assert property (over_holds_without_replay)
        else $error("mode left game over without replay");

    a_speed: assert property (speed_never_drops)
        else $error("speed decreased without replay");

    a_lfsr: assert property (lfsr_nonzero)
        else $error("lfsr reached zero");

endmodule

`default_nettype wire

// File: verification/dino_top_tb.sv
// Dino runner testbench
`default_nettype none

module dino_top_tb
    import dino_pkg::*;
;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int tick_cycles  = 4;
    localparam int frame_cycles = 1600 * 525;
    // First overlap once the cactus left edge passes dino_x + dino_w - 1
    localparam int hit_ticks    = 1200 - (100 + 32 - 1);
    localparam int run_cycles   = hit_ticks * tick_cycles;
    // Two frames, the wait for the banner row and the collision runs
    localparam int timeout_cycles = 2 * frame_cycles + 200 * 1600 + 8 * run_cycles + 10000;

    logic       clk;
    logic       reset;
    logic       replay;
    logic [7:0] vga_r;
    logic [7:0] vga_g;
    logic [7:0] vga_b;
    logic       vga_hs;
    logic       vga_vs;
    logic       vga_blank_n;
    logic       vga_clk;
    bcd_score_t score;
    logic       game_over;

    int          edges;
    int          cycle_count;
    int          check_count;
    int          error_count;

    dino_top #(
        .tick_cycles (tick_cycles)
    ) u_dino_top (
        .clk         (clk),
        .reset       (reset),
        .replay      (replay),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n),
        .vga_clk     (vga_clk),
        .score       (score),
        .game_over   (game_over)
    );

    bind game_state game_state_asserts u_game_state_asserts (
        .clk    (clk),
        .reset  (reset),
        .replay (replay),
        .mode   (mode),
        .speed  (speed),
        .lfsr   (lfsr)
    );

    always #10 clk = ~clk;

    // Clock edges since the end of reset give the raster position
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            edges <= 0;
        end else begin
            edges <= edges + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic logic [19:0] to_bcd(input int value);
        logic [19:0] result;
        int          rest;
        rest = value;
        for (int i = 0; i < 5; i++) begin
            result[4*i +: 4] = 4'(rest % 10);
            rest = rest / 10;
        end
        return result;
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error: %s is %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic reset_dut();
        @(negedge clk);
        reset  = 1'b1;
        replay = 1'b0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic wait_edges(input int target);
        while (edges < target) @(negedge clk);
    endtask

    task automatic pulse_replay();
        replay = 1'b1;
        @(negedge clk);
        replay = 1'b0;
    endtask

    // Samples the pixel drawn at (h, v) and can first restart a game that is over
    task automatic check_pixel(input int base, input int h, input int v,
                               input rgb_t expected, input string name,
                               input bit restart);
        int target;
        target = base + v * 1600 + h + 1;
        if (edges < target - 200) begin
            wait_edges(target - 200);
            if (restart && game_over) begin
                pulse_replay();
            end
        end
        wait_edges(target);
        check(name, {vga_r, vga_g, vga_b}, expected);
    endtask

    task automatic test_sync_timing();
        int errors_before;
        int hs_low;
        int blank_high;
        int vs_low;
        int p;
        errors_before = error_count;
        hs_low     = 0;
        blank_high = 0;
        vs_low     = 0;
        reset_dut();
        repeat (frame_cycles) begin
            @(negedge clk);
            p = edges - 1;
            hs_low     += (vga_hs == 1'b0) ? 1 : 0;
            vs_low     += (vga_vs == 1'b0) ? 1 : 0;
            blank_high += (vga_blank_n == 1'b1) ? 1 : 0;
            // Pixel clock follows the live pixel counter
            if (p < 1600) begin
                check("vga_clk", vga_clk, edges % 2);
            end
            if (p % 1600 == 1599) begin
                check("vga_hs low clocks", hs_low, 192);
                check("vga_blank_n high clocks", blank_high, (p / 1600 < 480) ? 1280 : 0);
                hs_low     = 0;
                blank_high = 0;
            end
        end
        check("vga_vs low clocks", vs_low, 2 * 1600);
        $display("test sync_timing finished with %0d errors", error_count - errors_before);
    endtask

    task automatic test_pixels();
        logic [7:0] zero_glyph [8];
        int         errors_before;
        errors_before = error_count;
        zero_glyph = '{8'h3c, 8'h66, 8'h6e, 8'h7e, 8'h76, 8'h66, 8'h3c, 8'h00};
        // Second frame, since the first one is spent on sync counting
        for (int row = 0; row < 8; row++) begin
            for (int col = 0; col < 8; col++) begin
                check_pixel(frame_cycles, 120 + col, 10 + row,
                            zero_glyph[row][7 - col] ? ink_rgb : sky_rgb, "score glyph rgb",
                            1'b1);
            end
        end
        check_pixel(frame_cycles, 600, 100, sky_rgb, "sky rgb", 1'b1);
        check_pixel(frame_cycles, 100, 348, dino_rgb, "dino rgb", 1'b1);
        $display("test pixels finished with %0d errors", error_count - errors_before);
    endtask

    task automatic test_collision();
        int errors_before;
        int score_edge;
        errors_before = error_count;
        score_edge = -1;
        reset_dut();
        check("game_over", game_over, 1'b0);
        while (!game_over) begin
            @(negedge clk);
            if (score == to_bcd(hit_ticks) && score_edge < 0) begin
                score_edge = edges;
            end
        end
        check("score", score, to_bcd(hit_ticks));
        check("score tick edge", score_edge, run_cycles);
        check("game_over edge", edges, score_edge + 1);
        $display("test collision finished with %0d errors", error_count - errors_before);
    endtask

    task automatic test_replay();
        int          errors_before;
        int          delay;
        int          ticks;
        logic [19:0] held;
        logic [19:0] last;
        errors_before = error_count;
        held  = score;
        delay = 16 + int'($urandom % 64);
        repeat (delay) begin
            @(negedge clk);
            check("score", score, held);
        end
        check_pixel(0, 560, 200, banner_rgb, "banner rgb", 1'b0);
        check("score", score, held);
        check("game_over", game_over, 1'b1);
        pulse_replay();
        check("game_over", game_over, 1'b0);
        ticks = 0;
        last  = score;
        while (!game_over) begin
            @(negedge clk);
            if (score != last) begin
                ticks++;
                last = score;
            end
        end
        check("ticks to collision", ticks, hit_ticks);
        check("score", score, to_bcd(2 * hit_ticks));
        $display("test replay finished with %0d errors", error_count - errors_before);
    endtask

    task automatic test_score_carry();
        int          errors_before;
        int          count;
        logic [19:0] last;
        errors_before = error_count;
        reset_dut();
        check("score", score, 20'h0);
        count = 0;
        last  = score;
        while (!game_over) begin
            @(negedge clk);
            if (score != last) begin
                count++;
                check("score", score, to_bcd(count));
                last = score;
            end
        end
        check("score", score, to_bcd(hit_ticks));
        $display("test score_carry finished with %0d errors", error_count - errors_before);
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        replay      = 1'b0;
        cycle_count = 0;
        check_count = 0;
        error_count = 0;
        void'($urandom(32'h158f_49a5));
        test_sync_timing();
        test_pixels();
        test_collision();
        test_replay();
        test_score_carry();
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
hdl/dino_pkg.sv
hdl/digit_font.sv
hdl/raster_timing.sv
hdl/game_state.sv
hdl/pixel_compositor.sv
hdl/dino_top.sv
verification/game_state_asserts.sv
verification/dino_top_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module dino_top_tb -f src.f -o dino_sim

output="$(./obj_dir/dino_sim)"
echo "$output"

if grep -qx "SIMULATION PASSED" <<< "$output"; then
    exit 0
fi
exit 1
